// File: logic/timekeeper_pkg.sv
package timekeeper_pkg;

   ////////////////////////////////////////
   // basic types

   typedef logic [31:0] word_t;      // host data word, also one half of the time.
   typedef logic [7:0]  sr_addr_t;
   typedef logic [63:0] vita_time_t; // seconds in [63:32], ticks in [31:0].

   // control register layout.
   typedef struct packed {
      logic set_imm;       // load at once instead of waiting for PPS.
      logic pps_polarity;  // 1 samples PPS on the rising clock edge.
   } time_ctrl_t;

   ////////////////////////////////////////
   // register offsets, added to BASE

   localparam sr_addr_t ADDR_NEXT_SECS  = 8'd0;
   localparam sr_addr_t ADDR_NEXT_TICKS = 8'd1;
   localparam sr_addr_t ADDR_TIME_CTRL  = 8'd2;
   localparam sr_addr_t ADDR_TRIG_SECS  = 8'd3;
   localparam sr_addr_t ADDR_TRIG_TICKS = 8'd4;

endpackage

// File: logic/setting_reg.sv
module setting_reg
   import timekeeper_pkg::*;
   #(
      parameter sr_addr_t my_addr   = 8'd0,
      parameter type      payload_t = word_t
   )
   (
      input  logic     clk,
      input  logic     rst,
      input  logic     strobe,
      input  sr_addr_t addr,
      input  word_t    in,
      output payload_t out,
      output logic     changed
   );

   localparam int W = $bits(payload_t);

   logic hit;

   assign hit = strobe && (addr == my_addr);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out     <= '0;
         changed <= 1'b0;
      end
      else
      begin
         if (hit)
            out <= payload_t'(in[W-1:0]); // only the low bits are kept.
         changed <= hit;
      end
   end

endmodule

// File: logic/time_settings.sv
module time_settings
   import timekeeper_pkg::*;
   #(
      parameter int BASE = 0
   )
   (
      input  logic       clk,
      input  logic       rst,
      input  logic       set_stb,
      input  sr_addr_t   set_addr,
      input  word_t      set_data,
      output word_t      next_secs,
      output word_t      next_ticks,
      output logic       load_req,
      output logic       set_imm,
      output logic       pps_polarity,
      output vita_time_t trig_time,
      output logic       arm_req
   );

   word_t      trig_secs;
   word_t      trig_ticks;
   time_ctrl_t ctrl;

   ////////////////////////////////////////
   // time preset

   // writing the seconds word is what requests the load.
   setting_reg #(.my_addr(sr_addr_t'(BASE + ADDR_NEXT_SECS)), .payload_t(word_t)) sr_next_secs
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .in(set_data),
       .out(next_secs), .changed(load_req));

   setting_reg #(.my_addr(sr_addr_t'(BASE + ADDR_NEXT_TICKS)), .payload_t(word_t)) sr_next_ticks
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .in(set_data),
       .out(next_ticks), .changed());

   setting_reg #(.my_addr(sr_addr_t'(BASE + ADDR_TIME_CTRL)), .payload_t(time_ctrl_t)) sr_ctrl
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .in(set_data),
       .out(ctrl), .changed());

   ////////////////////////////////////////
   // trigger time

   setting_reg #(.my_addr(sr_addr_t'(BASE + ADDR_TRIG_SECS)), .payload_t(word_t)) sr_trig_secs
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .in(set_data),
       .out(trig_secs), .changed());

   // the ticks word arms the trigger, so it goes last.
   setting_reg #(.my_addr(sr_addr_t'(BASE + ADDR_TRIG_TICKS)), .payload_t(word_t)) sr_trig_ticks
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .in(set_data),
       .out(trig_ticks), .changed(arm_req));

   assign set_imm      = ctrl.set_imm;
   assign pps_polarity = ctrl.pps_polarity;
   assign trig_time    = {trig_secs, trig_ticks};

   a_one_request : assert property (@(posedge clk) disable iff (rst) !(load_req && arm_req))
      else $error("load_req and arm_req high in the same cycle.");

endmodule

// File: logic/pps_capture.sv
module pps_capture
   (
      input  logic clk,
      input  logic rst,
      input  logic pps,
      input  logic pps_polarity,
      output logic pps_edge
   );

   logic       pps_reg_p;
   logic       pps_reg_n;
   logic       pps_sel;
   logic [1:0] pps_del;

   ////////////////////////////////////////
   // raw samples on both clock edges

   always_ff @(posedge clk)
      pps_reg_p <= pps;

   always_ff @(negedge clk)
      pps_reg_n <= pps;

   assign pps_sel = pps_polarity ? pps_reg_p : pps_reg_n;

   // two-stage history, the rising edge is new high over old low.
   always_ff @(posedge clk)
   begin
      if (rst)
         pps_del <= 2'b00;
      else
         pps_del <= {pps_del[0], pps_sel};
   end

   assign pps_edge = pps_del[0] & ~pps_del[1];

   a_edge_single : assert property (@(posedge clk) disable iff (rst) pps_edge |=> !pps_edge)
      else $error("pps_edge high in two consecutive cycles.");

endmodule

// File: logic/vita_time_counter.sv
module vita_time_counter
   import timekeeper_pkg::*;
   #(
      parameter word_t TICKS_PER_SEC = 32'd100_000_000
   )
   (
      input  logic       clk,
      input  logic       rst,
      input  logic       pps,
      input  logic       pps_polarity,
      input  logic       set_imm,
      input  logic       load_req,
      input  word_t      next_secs,
      input  word_t      next_ticks,
      output vita_time_t vita_time,
      output logic       pps_edge
   );

   localparam word_t ROLLOVER = TICKS_PER_SEC - 32'd1;

   word_t secs;
   word_t ticks;
   logic  load_req_q;
   logic  pending;
   logic  load_now;

   pps_capture pps_capture_inst
      (.clk(clk), .rst(rst), .pps(pps), .pps_polarity(pps_polarity), .pps_edge(pps_edge));

   assign load_now = pending & (set_imm | pps_edge);

   ////////////////////////////////////////
   // pending load

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         load_req_q <= 1'b0;
         pending    <= 1'b0;
      end
      else
      begin
         load_req_q <= load_req;
         if (load_req_q)
            pending <= 1'b1; // a new request wins over a load at the same edge.
         else if (load_now)
            pending <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // seconds and ticks

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (load_now)
      begin
         secs  <= next_secs;
         ticks <= next_ticks;
      end
      else if (ticks == ROLLOVER)
      begin
         secs  <= secs + 32'd1;
         ticks <= '0;
      end
      else
         ticks <= ticks + 32'd1;
   end

   assign vita_time = {secs, ticks};

   // a host preset may be out of range, so the cycle after a load is not checked.
   a_ticks_range : assert property (@(posedge clk) disable iff (rst)
                                    !$past(load_now) |-> (ticks <= ROLLOVER))
      else $error("ticks past the end of the second.");

endmodule

// File: logic/time_trigger.sv
module time_trigger
   import timekeeper_pkg::*;
   (
      input  logic       clk,
      input  logic       rst,
      input  vita_time_t vita_time,
      input  vita_time_t trig_time,
      input  logic       arm_req,
      input  logic       pps_edge,
      output logic       trig_stb,
      output vita_time_t pps_time
   );

   logic armed;

   // fires once the running time is at or past the target.
   assign trig_stb = armed && (vita_time >= trig_time);

   ////////////////////////////////////////
   // arming

   always_ff @(posedge clk)
   begin
      if (rst)
         armed <= 1'b0;
      else if (arm_req)
         armed <= 1'b1;
      else if (trig_stb)
         armed <= 1'b0; // one strobe per arming.
   end

   ////////////////////////////////////////
   // time stamp at PPS

   always_ff @(posedge clk)
   begin
      if (rst)
         pps_time <= '0;
      else if (pps_edge)
         pps_time <= vita_time;
   end

   // a rearm at the firing edge may legally fire again.
   a_stb_single : assert property (@(posedge clk) disable iff (rst)
                                   (trig_stb && !arm_req) |=> !trig_stb)
      else $error("trig_stb high two cycles in a row.");

endmodule

// File: logic/vita_timekeeper.sv
module vita_timekeeper
   import timekeeper_pkg::*;
   #(
      parameter word_t TICKS_PER_SEC = 32'd100_000_000,
      parameter int    BASE          = 0
   )
   (
      input  logic       clk,
      input  logic       rst,
      input  logic       set_stb,
      input  sr_addr_t   set_addr,
      input  word_t      set_data,
      input  logic       pps,
      output vita_time_t vita_time,
      output logic       pps_int,
      output logic       trig_stb,
      output vita_time_t pps_time
   );

   word_t      next_secs;
   word_t      next_ticks;
   logic       load_req;
   logic       set_imm;
   logic       pps_polarity;
   vita_time_t trig_time;
   logic       arm_req;

   ////////////////////////////////////////
   // decode

   time_settings #(.BASE(BASE)) time_settings_inst
      (.clk(clk), .rst(rst),
       .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
       .next_secs(next_secs), .next_ticks(next_ticks), .load_req(load_req),
       .set_imm(set_imm), .pps_polarity(pps_polarity),
       .trig_time(trig_time), .arm_req(arm_req));

   ////////////////////////////////////////
   // execute

   vita_time_counter #(.TICKS_PER_SEC(TICKS_PER_SEC)) vita_time_counter_inst
      (.clk(clk), .rst(rst), .pps(pps), .pps_polarity(pps_polarity),
       .set_imm(set_imm), .load_req(load_req),
       .next_secs(next_secs), .next_ticks(next_ticks),
       .vita_time(vita_time), .pps_edge(pps_int)); // the edge pulse leaves as pps_int.

   ////////////////////////////////////////
   // result

   time_trigger time_trigger_inst
      (.clk(clk), .rst(rst), .vita_time(vita_time), .trig_time(trig_time),
       .arm_req(arm_req), .pps_edge(pps_int),
       .trig_stb(trig_stb), .pps_time(pps_time));

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen
   (
      output logic clk,
      output logic rst
   );

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period.
   end

   // reset covers the first five rising edges.
   initial
   begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// File: test/tb_vita_timekeeper.sv
module tb_vita_timekeeper
   import timekeeper_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam word_t TPS    = 32'd100;
   localparam int    BASE   = 16;
   localparam int    N_FREE = 300;
   localparam int    N_IMM  = 6;
   localparam int    N_PPS  = 8;
   localparam int    N_TRIG = 4;
   localparam int    N_DEC  = 200;
   // cycle budget of all tests, then a margin on top.
   localparam int    BUDGET = N_FREE + 30 * N_IMM + 120 * N_PPS + 550 * N_TRIG + N_DEC + 100;
   localparam int    TIMEOUT_NS = (BUDGET + 500) * 4;

   logic       clk;
   logic       rst;
   logic       set_stb;
   sr_addr_t   set_addr;
   word_t      set_data;
   logic       pps;
   vita_time_t vita_time;
   logic       pps_int;
   logic       trig_stb;
   vita_time_t pps_time;

   // reference model state, as it stands after the last edge.
   word_t      m_secs;
   word_t      m_ticks;
   word_t      m_next_secs;
   word_t      m_next_ticks;
   word_t      m_trig_secs;
   word_t      m_trig_ticks;
   logic       m_set_imm;
   logic       m_load_req;
   logic       m_load_req_q;
   logic       m_pending;
   logic       m_arm_req;
   logic       m_armed;
   vita_time_t m_pps_time;
   logic       pps_seen;    // pps_int during the cycle before the next edge.
   vita_time_t stamp;
   int         n_pps;
   int         n_int;
   int         n_stb;

   tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

   vita_timekeeper #(.TICKS_PER_SEC(TPS), .BASE(BASE)) vita_timekeeper_inst
      (.clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
       .pps(pps), .vita_time(vita_time), .pps_int(pps_int), .trig_stb(trig_stb),
       .pps_time(pps_time));

   ////////////////////////////////////////
   // helpers

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("tests failed");
         $fatal(1, "stopped at the first mismatch.");
      end
   endtask

   function automatic sr_addr_t reg_addr(input sr_addr_t offs);
      return sr_addr_t'(BASE + int'(offs));
   endfunction

   function automatic logic hit(input sr_addr_t offs);
      return set_stb && (set_addr == reg_addr(offs));
   endfunction

   // one clock edge: advance the model, then compare the DUT with it.
   task automatic tick();
      logic       load_now;
      logic       fire;
      vita_time_t now;
      @(posedge clk);
      #1;
      now      = {m_secs, m_ticks};
      load_now = m_pending && (m_set_imm || pps_seen);
      fire     = m_armed && (now >= {m_trig_secs, m_trig_ticks});
      if (pps_seen)
         m_pps_time = now;
      if (m_load_req_q)
         m_pending = 1'b1; // a fresh request keeps the load pending.
      else if (load_now)
         m_pending = 1'b0;
      m_load_req_q = m_load_req;
      if (m_arm_req)
         m_armed = 1'b1;
      else if (fire)
         m_armed = 1'b0;
      if (load_now)
      begin
         m_secs  = m_next_secs;
         m_ticks = m_next_ticks;
      end
      else if (m_ticks == TPS - 32'd1)
      begin
         m_secs  = m_secs + 32'd1;
         m_ticks = '0;
      end
      else
         m_ticks = m_ticks + 32'd1;
      m_load_req = hit(ADDR_NEXT_SECS);
      m_arm_req  = hit(ADDR_TRIG_TICKS);
      if (hit(ADDR_NEXT_SECS))
         m_next_secs = set_data;
      if (hit(ADDR_NEXT_TICKS))
         m_next_ticks = set_data;
      if (hit(ADDR_TIME_CTRL))
         m_set_imm = set_data[1];
      if (hit(ADDR_TRIG_SECS))
         m_trig_secs = set_data;
      if (hit(ADDR_TRIG_TICKS))
         m_trig_ticks = set_data;
      check("vita_time", vita_time, {m_secs, m_ticks});
      check("pps_time", pps_time, m_pps_time);
      check("trig_stb", 64'(trig_stb),
            64'(m_armed && ({m_secs, m_ticks} >= {m_trig_secs, m_trig_ticks})));
      pps_seen = pps_int;
      if (pps_int)
      begin
         n_int++;
         stamp = vita_time;
      end
      if (trig_stb)
         n_stb++;
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   task automatic write_reg(input sr_addr_t a, input word_t d);
      set_stb  = 1'b1;
      set_addr = a;
      set_data = d;
      tick();
      set_stb  = 1'b0;
   endtask

   task automatic pps_pulse(input int width);
      pps = 1'b1;
      n_pps++;
      idle(width);
      pps = 1'b0;
   endtask

   ////////////////////////////////////////
   // tests

   initial
   begin
      word_t    secs;
      word_t    ticks;
      word_t    t;
      word_t    tsecs;
      word_t    tticks;
      sr_addr_t a;
      int       k;
      int       s;
      int       offs;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      pps      = 1'b0;
      {m_secs, m_ticks, m_next_secs, m_next_ticks, m_trig_secs, m_trig_ticks} = '0;
      {m_set_imm, m_load_req, m_load_req_q, m_pending, m_arm_req, m_armed} = '0;
      m_pps_time = '0;
      pps_seen   = 1'b0;
      stamp      = '0;
      n_pps      = 0;
      n_int      = 0;
      n_stb      = 0;
      void'($urandom(32'hbd37_2672));
      @(negedge rst);

      check("vita_time", vita_time, 64'd0);
      idle(N_FREE); // several rollovers at 100 ticks per second.

      write_reg(reg_addr(ADDR_TIME_CTRL), 32'h2 | ($urandom & 32'h1));
      for (int i = 0; i < N_IMM; i++)
      begin
         secs  = $urandom;
         ticks = $urandom % TPS;
         write_reg(reg_addr(ADDR_NEXT_TICKS), ticks);
         write_reg(reg_addr(ADDR_NEXT_SECS), secs);
         idle(3);
         check("vita_time after load", vita_time, {secs, ticks});
         idle(5 + $urandom % 15);
      end

      write_reg(reg_addr(ADDR_TIME_CTRL), $urandom & 32'h1);
      idle(4);
      for (int i = 0; i < N_PPS; i++)
      begin
         secs  = $urandom;
         ticks = $urandom % TPS;
         write_reg(reg_addr(ADDR_NEXT_TICKS), ticks);
         write_reg(reg_addr(ADDR_NEXT_SECS), secs);
         idle(5 + $urandom % 20);
         pps = 1'b1;
         n_pps++;
         k = 0;
         while (!pps_int && k < 6)
         begin
            tick();
            k++;
         end
         check("pps_int", 64'(pps_int), 64'd1);
         tick();
         check("vita_time after pps_int", vita_time, {secs, ticks});
         idle(4);
         pps = 1'b0;
         idle(8);
         pps_pulse(4 + $urandom % 4);  // no load is pending any more.
         idle(8);
      end

      for (int i = 0; i < N_PPS; i++)
      begin
         write_reg(reg_addr(ADDR_TIME_CTRL), $urandom & 32'h1);
         idle(4);
         k = n_int;
         pps_pulse(4 + $urandom % 6);
         idle(4 + $urandom % 10);
         check("pps_int pulses", 64'(n_int), 64'(k + 1));
         check("pps_time", pps_time, stamp);
      end

      for (int i = 0; i < N_TRIG; i++)
      begin
         offs   = 200 + int'($urandom % 300);
         t      = m_ticks + word_t'(offs);
         tsecs  = m_secs + t / TPS;
         tticks = t % TPS;
         s      = n_stb;
         write_reg(reg_addr(ADDR_TRIG_SECS), tsecs);
         write_reg(reg_addr(ADDR_TRIG_TICKS), tticks);
         k = 0;
         while (!trig_stb && k < offs + 20)
         begin
            tick();
            k++;
         end
         check("vita_time at trig_stb", vita_time, {tsecs, tticks});
         idle(10);
         check("trig_stb pulses", 64'(n_stb), 64'(s + 1));
      end
      // a target in the past fires right after arming.
      s = n_stb;
      write_reg(reg_addr(ADDR_TRIG_SECS), 32'd0);
      write_reg(reg_addr(ADDR_TRIG_TICKS), 32'd0);
      tick();
      check("trig_stb", 64'(trig_stb), 64'd1);
      idle(5);
      check("trig_stb pulses", 64'(n_stb), 64'(s + 1));

      // with set_imm on, a stray seconds write shows up at once as a load.
      write_reg(reg_addr(ADDR_TIME_CTRL), 32'h2);
      for (int i = 0; i < N_DEC; i++)
      begin
         a = sr_addr_t'($urandom);
         if (a >= reg_addr(ADDR_NEXT_SECS) && a <= reg_addr(ADDR_TRIG_TICKS))
            a = a + 8'd8;
         write_reg(a, $urandom);
      end
      // a load and a fresh arming expose any stray preset, control or trigger write.
      write_reg(reg_addr(ADDR_NEXT_SECS), $urandom);
      write_reg(reg_addr(ADDR_TRIG_TICKS), 32'd0);

      idle(10);
      check("pps_int count", 64'(n_int), 64'(n_pps));
      $display("all tests passed");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: the run took longer than its cycle budget.");
      $display("tests failed");
      $fatal(1, "watchdog expired.");
   end

endmodule

// File: build.f
logic/timekeeper_pkg.sv
logic/setting_reg.sv
logic/time_settings.sv
logic/pps_capture.sv
logic/vita_time_counter.sv
logic/time_trigger.sv
logic/vita_timekeeper.sv
test/tb_clock_gen.sv
test/tb_vita_timekeeper.sv

// File: Makefile
SIM        = verilator
TOP        = tb_vita_timekeeper
FILELIST   = build.f
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
